// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath word width
`define DATA_W 32

// general register address width
`define REG_AW 5

// cycles a multiply-class op holds the pipeline, result cycle included
`define MUL_CYCLES 2

// one quotient bit per iteration
`define DIV_ITERS 32

`endif

// File: verilog/cpu_pkg.sv
package cpu_pkg;

typedef enum logic [5:0] {
	OP_NOP,

	// logical and arithmetic
	OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI,
	OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
	OP_SLT, OP_SLTU,

	// shifts
	OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,

	// conditional moves, bit count, link
	OP_MOVZ, OP_MOVN, OP_CLZ, OP_CLO,
	OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL,

	// hi/lo access
	OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,

	// multi-cycle
	OP_MUL, OP_MULT, OP_MULTU,
	OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
	OP_DIV, OP_DIVU,

	// loads and stores
	OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
	OP_SB, OP_SH, OP_SW,

	// traps and system calls
	OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU,
	OP_SYSCALL, OP_BREAK
} oper_t;

// cause register codes
typedef enum logic [4:0] {
	EXC_NONE = 5'd0,
	EXC_ADEL = 5'd4,
	EXC_ADES = 5'd5,
	EXC_SYS  = 5'd8,
	EXC_BP   = 5'd9,
	EXC_OV   = 5'd12,
	EXC_TR   = 5'd13
} exccode_t;

endpackage

// File: verilog/ex_count_bit.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module ex_count_bit(
	input  logic               bit_val,
	input  logic [`DATA_W-1:0] val,
	output logic [`DATA_W-1:0] count
);

// highest differing bit wins, all-match leaves the full width
always_comb
begin
	count = `DATA_W'(`DATA_W);
	for (int i = 0; i < `DATA_W; i++)
	begin
		if (val[i] != bit_val)
		begin
			count = `DATA_W'(`DATA_W - 1 - i);
		end
	end
end

endmodule

// File: verilog/ex_multi_cyc.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module ex_multi_cyc
	import cpu_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 flush,
	input  oper_t                op,
	input  logic [`DATA_W-1:0]   reg1,
	input  logic [`DATA_W-1:0]   reg2,
	input  logic [2*`DATA_W-1:0] hilo,
	output logic [2*`DATA_W-1:0] ret,
	output logic [`DATA_W-1:0]   mult_word,
	output logic                 busy
);

localparam int CNT_W = $clog2(`DIV_ITERS + 1);

typedef enum logic [1:0] {S_IDLE, S_MUL, S_DIV, S_DONE} state_t;

state_t             state;
logic [CNT_W-1:0]   cnt;
logic               is_mul, is_div, is_signed;

assign is_mul = op inside {OP_MUL, OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
assign is_div = op inside {OP_DIV, OP_DIVU};
assign is_signed = !(op inside {OP_MULTU, OP_MADDU, OP_MSUBU, OP_DIVU});

assign busy = !flush && ((state == S_IDLE && (is_mul || is_div)) ||
	state == S_MUL || state == S_DIV);

always_ff @(posedge clk)
begin
	if (rst || flush)
	begin
		state <= S_IDLE;
		cnt <= '0;
	end
	else
	begin
		case (state)
		S_IDLE:
		begin
			if (is_div)
			begin
				state <= S_DIV;
				cnt <= '0;
			end
			else if (is_mul)
			begin
				state <= (`MUL_CYCLES > 2) ? S_MUL : S_DONE;
				cnt <= CNT_W'(1);
			end
		end
		S_MUL:
		begin
			cnt <= cnt + CNT_W'(1);
			if (cnt >= CNT_W'(`MUL_CYCLES - 2))
			begin
				state <= S_DONE;
			end
		end
		S_DIV:
		begin
			cnt <= cnt + CNT_W'(1);
			if (cnt == CNT_W'(`DIV_ITERS - 1))
			begin
				state <= S_DONE;
			end
		end
		default:
		begin
			// result taken this cycle
			state <= S_IDLE;
		end
		endcase
	end
end

// operands sampled on the first cycle, while forwarding is still valid
logic [2*`DATA_W-1:0] op1_ext, op2_ext, prod_q, mul_acc;
logic [`DATA_W-1:0]   abs1, abs2, div_r, div_q, div_d, quo_fix, rem_fix;
logic [`DATA_W:0]     trial;
logic                 neg_q, neg_r;

assign op1_ext = {{`DATA_W{is_signed & reg1[`DATA_W-1]}}, reg1};
assign op2_ext = {{`DATA_W{is_signed & reg2[`DATA_W-1]}}, reg2};
assign abs1 = (is_signed && reg1[`DATA_W-1]) ? -reg1 : reg1;
assign abs2 = (is_signed && reg2[`DATA_W-1]) ? -reg2 : reg2;
assign trial = {div_r, div_q[`DATA_W-1]} - {1'b0, div_d};

always_ff @(posedge clk)
begin
	if (state == S_IDLE)
	begin
		prod_q <= op1_ext * op2_ext;
		div_r <= '0;
		div_q <= abs1;
		div_d <= abs2;
		// zero divisor keeps the all-ones quotient
		neg_q <= is_signed && (reg1[`DATA_W-1] ^ reg2[`DATA_W-1]) && (reg2 != '0);
		neg_r <= is_signed && reg1[`DATA_W-1];
	end
	else if (state == S_DIV)
	begin
		if (!trial[`DATA_W])
		begin
			div_r <= trial[`DATA_W-1:0];
			div_q <= {div_q[`DATA_W-2:0], 1'b1};
		end
		else
		begin
			div_r <= {div_r[`DATA_W-2:0], div_q[`DATA_W-1]};
			div_q <= {div_q[`DATA_W-2:0], 1'b0};
		end
	end
end

always_comb
begin
	case (op)
	OP_MADD, OP_MADDU: mul_acc = hilo + prod_q;
	OP_MSUB, OP_MSUBU: mul_acc = hilo - prod_q;
	default:           mul_acc = prod_q;
	endcase
end

assign quo_fix = neg_q ? -div_q : div_q;
assign rem_fix = neg_r ? -div_r : div_r;
assign ret = is_div ? {rem_fix, quo_fix} : mul_acc;
assign mult_word = prod_q[`DATA_W-1:0];

logic [CNT_W:0] busy_len;

always_ff @(posedge clk)
begin
	if (rst || !busy)
	begin
		busy_len <= '0;
	end
	else
	begin
		busy_len <= busy_len + (CNT_W+1)'(1);
	end
end

// longest hold is the divide, one load cycle plus the iterations
assert property (@(posedge clk) disable iff (rst) busy_len <= (CNT_W+1)'(`DIV_ITERS + 2))
	else $error("multi-cycle unit stuck busy");

// upstream has to hold the op until the result is taken
assert property (@(posedge clk) disable iff (rst || flush) busy |=> op == $past(op))
	else $error("op changed while multi-cycle unit busy");

endmodule

// File: verilog/cpu_ex.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_ex
	import cpu_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 flush,
	input  oper_t                op,
	input  logic [`DATA_W-1:0]   pc,
	input  logic [`DATA_W-1:0]   reg1,
	input  logic [`DATA_W-1:0]   reg2,
	input  logic [`DATA_W-1:0]   imm,
	input  logic [`REG_AW-1:0]   reg_addr1,
	input  logic [`REG_AW-1:0]   reg_addr2,
	input  logic [`REG_AW-1:0]   rd_addr,
	input  logic [4:0]           shamt,
	input  logic                 rd_we,
	input  logic                 fwd_we,
	input  logic [`REG_AW-1:0]   fwd_addr,
	input  logic [`DATA_W-1:0]   fwd_data,
	input  logic [2*`DATA_W-1:0] hilo,
	output logic                 stall_req,
	output logic                 res_we,
	output logic [`REG_AW-1:0]   res_addr,
	output logic [`DATA_W-1:0]   res_data,
	output logic                 hilo_we,
	output logic [2*`DATA_W-1:0] hilo_wdata,
	output logic                 mem_ce,
	output logic                 mem_we,
	output logic [`DATA_W-1:0]   mem_addr,
	output logic [`DATA_W-1:0]   mem_wdata,
	output logic [3:0]           mem_sel,
	output logic                 except_occur,
	output exccode_t             except_code,
	output logic [`DATA_W-1:0]   except_extra
);

// forwarding from the EX/MEM register
logic [`DATA_W-1:0] src1, src2;
assign src1 = (fwd_we && fwd_addr == reg_addr1) ? fwd_data : reg1;
assign src2 = (fwd_we && fwd_addr == reg_addr2) ? fwd_data : reg2;

logic [`DATA_W-1:0] hi, lo;
assign {hi, lo} = hilo;

logic [`DATA_W-1:0] add_u, sub_u;
logic               signed_lt, unsigned_lt, ov_add, ov_sub;

assign add_u = src1 + src2;
assign sub_u = src1 - src2;
assign signed_lt = (src1[`DATA_W-1] != src2[`DATA_W-1]) ? src1[`DATA_W-1] : sub_u[`DATA_W-1];
assign unsigned_lt = (src1 < src2);
assign ov_add = (src1[`DATA_W-1] == src2[`DATA_W-1]) && (add_u[`DATA_W-1] != src1[`DATA_W-1]);
assign ov_sub = (src1[`DATA_W-1] != src2[`DATA_W-1]) && (sub_u[`DATA_W-1] != src1[`DATA_W-1]);

logic [`DATA_W-1:0] clz_cnt, clo_cnt;

ex_count_bit u_clz(
	.bit_val(1'b0),
	.val(src1),
	.count(clz_cnt)
);

ex_count_bit u_clo(
	.bit_val(1'b1),
	.val(src1),
	.count(clo_cnt)
);

logic [2*`DATA_W-1:0] multi_ret;
logic [`DATA_W-1:0]   mult_word;

ex_multi_cyc u_multi_cyc(
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.op(op),
	.reg1(src1),
	.reg2(src2),
	.hilo(hilo),
	.ret(multi_ret),
	.mult_word(mult_word),
	.busy(stall_req)
);

assign res_we = rd_we;
assign res_addr = rd_addr;
assign hilo_we = op inside {OP_MTHI, OP_MTLO, OP_MULT, OP_MULTU, OP_MADD, OP_MADDU,
	OP_MSUB, OP_MSUBU, OP_DIV, OP_DIVU};

always_comb
begin
	res_data = '0;
	hilo_wdata = hilo;
	case (op)
	OP_AND:  res_data = src1 & src2;
	OP_OR:   res_data = src1 | src2;
	OP_XOR:  res_data = src1 ^ src2;
	OP_NOR:  res_data = ~(src1 | src2);
	OP_LUI:  res_data = {imm[15:0], 16'b0};
	OP_ADD, OP_ADDU: res_data = add_u;
	OP_SUB, OP_SUBU: res_data = sub_u;
	OP_SLT:  res_data = {{(`DATA_W-1){1'b0}}, signed_lt};
	OP_SLTU: res_data = {{(`DATA_W-1){1'b0}}, unsigned_lt};
	OP_SLL:  res_data = src2 << shamt;
	OP_SRL:  res_data = src2 >> shamt;
	OP_SRA:  res_data = $signed(src2) >>> shamt;
	OP_SLLV: res_data = src2 << src1[4:0];
	OP_SRLV: res_data = src2 >> src1[4:0];
	OP_SRAV: res_data = $signed(src2) >>> src1[4:0];
	// write enable for the moves is resolved in decode
	OP_MOVZ, OP_MOVN: res_data = src1;
	OP_CLZ:  res_data = clz_cnt;
	OP_CLO:  res_data = clo_cnt;
	OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL: res_data = pc + `DATA_W'd8;
	OP_MFHI: res_data = hi;
	OP_MFLO: res_data = lo;
	OP_MTHI: hilo_wdata = {src1, lo};
	OP_MTLO: hilo_wdata = {hi, src1};
	OP_MUL:  res_data = mult_word;
	OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU, OP_DIV, OP_DIVU:
		hilo_wdata = multi_ret;
	default: res_data = '0;
	endcase
end

// memory request
logic is_load, is_store;
assign is_load = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
assign is_store = op inside {OP_SB, OP_SH, OP_SW};
assign mem_ce = is_load | is_store;
assign mem_we = is_store;
assign mem_addr = src1 + imm;

always_comb
begin
	case (op)
	OP_LW, OP_SW:
	begin
		mem_sel = 4'b1111;
		mem_wdata = src2;
	end
	OP_LB, OP_LBU, OP_SB:
	begin
		mem_sel = 4'b0001 << mem_addr[1:0];
		mem_wdata = src2 << {mem_addr[1:0], 3'b000};
	end
	OP_LH, OP_LHU, OP_SH:
	begin
		mem_sel = mem_addr[1] ? 4'b1100 : 4'b0011;
		mem_wdata = mem_addr[1] ? (src2 << 16) : src2;
	end
	default:
	begin
		mem_sel = 4'b0000;
		mem_wdata = '0;
	end
	endcase
end

exccode_t exc_cause;

always_comb
begin
	except_occur = 1'b0;
	exc_cause = EXC_TR;
	case (op)
	OP_TEQ:  except_occur = (src1 == src2);
	OP_TNE:  except_occur = (src1 != src2);
	OP_TGE:  except_occur = ~signed_lt;
	OP_TLT:  except_occur = signed_lt;
	OP_TGEU: except_occur = ~unsigned_lt;
	OP_TLTU: except_occur = unsigned_lt;
	OP_LW, OP_SW:
	begin
		except_occur = |mem_addr[1:0];
		exc_cause = is_store ? EXC_ADES : EXC_ADEL;
	end
	OP_LH, OP_LHU, OP_SH:
	begin
		except_occur = mem_addr[0];
		exc_cause = is_store ? EXC_ADES : EXC_ADEL;
	end
	OP_SYSCALL:
	begin
		except_occur = 1'b1;
		exc_cause = EXC_SYS;
	end
	OP_BREAK:
	begin
		except_occur = 1'b1;
		exc_cause = EXC_BP;
	end
	OP_ADD:
	begin
		except_occur = ov_add;
		exc_cause = EXC_OV;
	end
	OP_SUB:
	begin
		except_occur = ov_sub;
		exc_cause = EXC_OV;
	end
	default: except_occur = 1'b0;
	endcase
end

assign except_code = except_occur ? exc_cause : EXC_NONE;
// only an address error raises an exception on a memory op
assign except_extra = (except_occur && mem_ce) ? mem_addr : '0;

assert property (@(posedge clk) disable iff (rst) mem_ce |-> mem_sel != 4'b0000)
	else $error("memory request with no byte lane");

endmodule

// File: verilog/ex_stage.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module ex_stage
	import cpu_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               flush,
	input  oper_t              op,
	input  logic [`DATA_W-1:0] pc,
	input  logic [`DATA_W-1:0] reg1,
	input  logic [`DATA_W-1:0] reg2,
	input  logic [`DATA_W-1:0] imm,
	input  logic [`REG_AW-1:0] reg_addr1,
	input  logic [`REG_AW-1:0] reg_addr2,
	input  logic [`REG_AW-1:0] rd_addr,
	input  logic [4:0]         shamt,
	input  logic               rd_we,
	output logic               stall_req,
	output logic               wb_we,
	output logic [`REG_AW-1:0] wb_addr,
	output logic [`DATA_W-1:0] wb_data,
	output logic               mem_ce,
	output logic               mem_we,
	output logic [`DATA_W-1:0] mem_addr,
	output logic [`DATA_W-1:0] mem_wdata,
	output logic [3:0]         mem_sel,
	output logic               except_occur,
	output exccode_t           except_code,
	output logic [`DATA_W-1:0] except_extra,
	output logic [`DATA_W-1:0] hi,
	output logic [`DATA_W-1:0] lo
);

logic                 res_we, hilo_we, ex_mem_ce, ex_mem_we, ex_exc_occur;
logic [`REG_AW-1:0]   res_addr;
logic [`DATA_W-1:0]   res_data, ex_mem_addr, ex_mem_wdata, ex_exc_extra;
logic [3:0]           ex_mem_sel;
exccode_t             ex_exc_code;
logic [2*`DATA_W-1:0] hilo_q, hilo_wdata;
logic                 bubble;

cpu_ex u_cpu_ex(
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.op(op),
	.pc(pc),
	.reg1(reg1),
	.reg2(reg2),
	.imm(imm),
	.reg_addr1(reg_addr1),
	.reg_addr2(reg_addr2),
	.rd_addr(rd_addr),
	.shamt(shamt),
	.rd_we(rd_we),
	.fwd_we(wb_we),
	.fwd_addr(wb_addr),
	.fwd_data(wb_data),
	.hilo(hilo_q),
	.stall_req(stall_req),
	.res_we(res_we),
	.res_addr(res_addr),
	.res_data(res_data),
	.hilo_we(hilo_we),
	.hilo_wdata(hilo_wdata),
	.mem_ce(ex_mem_ce),
	.mem_we(ex_mem_we),
	.mem_addr(ex_mem_addr),
	.mem_wdata(ex_mem_wdata),
	.mem_sel(ex_mem_sel),
	.except_occur(ex_exc_occur),
	.except_code(ex_exc_code),
	.except_extra(ex_exc_extra)
);

// stalled or flushed cycles leave the stage as a bubble
assign bubble = stall_req | flush;

always_ff @(posedge clk)
begin
	if (rst || bubble)
	begin
		wb_we <= 1'b0;
		wb_addr <= '0;
		wb_data <= '0;
		mem_ce <= 1'b0;
		mem_we <= 1'b0;
		except_occur <= 1'b0;
		except_code <= EXC_NONE;
		except_extra <= '0;
	end
	else
	begin
		wb_we <= res_we;
		wb_addr <= res_addr;
		wb_data <= res_data;
		mem_ce <= ex_mem_ce;
		mem_we <= ex_mem_we;
		except_occur <= ex_exc_occur;
		except_code <= ex_exc_code;
		except_extra <= ex_exc_extra;
	end
end

always_ff @(posedge clk)
begin
	if (!bubble)
	begin
		mem_addr <= ex_mem_addr;
		mem_wdata <= ex_mem_wdata;
		mem_sel <= ex_mem_sel;
	end
end

// commit only when the result leaves the stage
always_ff @(posedge clk)
begin
	if (rst)
	begin
		hilo_q <= '0;
	end
	else if (hilo_we && !bubble)
	begin
		hilo_q <= hilo_wdata;
	end
end

assign hi = hilo_q[2*`DATA_W-1:`DATA_W];
assign lo = hilo_q[`DATA_W-1:0];

endmodule

// File: sim/tb_ex_stage.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module tb_ex_stage
	import cpu_pkg::*;
();

// every op budgeted as a full divide
localparam int N_OPS = 140;
localparam int WATCHDOG_NS = N_OPS * (`DIV_ITERS + 4) * 4 + 400;

logic               clk, rst, flush, rd_we;
oper_t              op;
logic [`DATA_W-1:0] pc, reg1, reg2, imm;
logic [`REG_AW-1:0] reg_addr1, reg_addr2, rd_addr;
logic [4:0]         shamt;
logic               stall_req, wb_we, mem_ce, mem_we, except_occur;
logic [`REG_AW-1:0] wb_addr;
logic [`DATA_W-1:0] wb_data, mem_addr, mem_wdata, except_extra, hi, lo;
logic [3:0]         mem_sel;
exccode_t           except_code;

logic [31:0] rng;
int          errors;
oper_t       alu_ops [18];

ex_stage u_dut(
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.op(op),
	.pc(pc),
	.reg1(reg1),
	.reg2(reg2),
	.imm(imm),
	.reg_addr1(reg_addr1),
	.reg_addr2(reg_addr2),
	.rd_addr(rd_addr),
	.shamt(shamt),
	.rd_we(rd_we),
	.stall_req(stall_req),
	.wb_we(wb_we),
	.wb_addr(wb_addr),
	.wb_data(wb_data),
	.mem_ce(mem_ce),
	.mem_we(mem_we),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.mem_sel(mem_sel),
	.except_occur(except_occur),
	.except_code(except_code),
	.except_extra(except_extra),
	.hi(hi),
	.lo(lo)
);

initial
begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

function automatic logic [31:0] next_rand();
	rng = rng * 32'd1103515245 + 32'd12345;
	return {rng[15:0], rng[31:16]};
endfunction

function automatic logic [31:0] count_lead(input logic [31:0] v, input logic b);
	int n;
	n = 0;
	for (int i = 31; i >= 0; i--)
	begin
		if (v[i] != b)
			break;
		n++;
	end
	return 32'(n);
endfunction

function automatic logic [31:0] alu_model(input oper_t o, input logic [31:0] a,
	input logic [31:0] b, input logic [31:0] im, input logic [4:0] sh, input logic [31:0] pcv);
	case (o)
	OP_ADDU: return a + b;
	OP_SUBU: return a - b;
	OP_AND:  return a & b;
	OP_OR:   return a | b;
	OP_XOR:  return a ^ b;
	OP_NOR:  return ~(a | b);
	OP_SLL:  return b << sh;
	OP_SRL:  return b >> sh;
	OP_SRA:  return $signed(b) >>> sh;
	OP_SLLV: return b << a[4:0];
	OP_SRLV: return b >> a[4:0];
	OP_SRAV: return $signed(b) >>> a[4:0];
	OP_SLT:  return {31'd0, $signed(a) < $signed(b)};
	OP_SLTU: return {31'd0, a < b};
	OP_LUI:  return {im[15:0], 16'd0};
	OP_CLZ:  return count_lead(a, 1'b0);
	OP_CLO:  return count_lead(a, 1'b1);
	OP_JAL:  return pcv + 32'd8;
	default: return 32'd0;
	endcase
endfunction

function automatic logic [63:0] mul_model(input logic [31:0] a, input logic [31:0] b,
	input logic sgn);
	longint sa, sb;
	if (!sgn)
		return {32'd0, a} * {32'd0, b};
	sa = longint'($signed(a));
	sb = longint'($signed(b));
	return 64'(sa * sb);
endfunction

// remainder in the high word and quotient in the low word
function automatic logic [63:0] div_model(input logic [31:0] a, input logic [31:0] b,
	input logic sgn);
	logic [31:0] q, r;
	if (b == 32'd0)
		return {a, 32'hffff_ffff};
	if (sgn)
	begin
		q = $signed(a) / $signed(b);
		r = $signed(a) % $signed(b);
	end
	else
	begin
		q = a / b;
		r = a % b;
	end
	return {r, q};
endfunction

task automatic report_mismatch(input string test, input logic [63:0] exp,
	input logic [63:0] act);
	$display("mismatch %s: expected %h, actual %h", test, exp, act);
	errors++;
endtask

task automatic report_fault(input string msg);
	$display("error: %s", msg);
	errors++;
endtask

task automatic next_cycle();
	@(posedge clk);
	#1;
endtask

task automatic drive_op(input oper_t o, input logic [31:0] a, input logic [31:0] b,
	input logic [31:0] im, input logic [4:0] sh, input logic we, input logic [4:0] ra);
	op = o;
	reg1 = a;
	reg2 = b;
	imm = im;
	shamt = sh;
	rd_we = we;
	rd_addr = ra;
	reg_addr1 = 5'd1;
	reg_addr2 = 5'd2;
endtask

task automatic check_reset();
	if ({wb_we, mem_ce, mem_we, except_occur, stall_req} !== 5'd0)
		report_mismatch("reset_ctrl", 64'd0,
			64'({wb_we, mem_ce, mem_we, except_occur, stall_req}));
	if ({hi, lo} !== 64'd0)
		report_mismatch("reset_hilo", 64'd0, {hi, lo});
endtask

task automatic alu_case(input oper_t o, input logic [31:0] a, input logic [31:0] b,
	input logic [31:0] im, input logic [4:0] sh, input logic we, input logic [4:0] ra);
	logic [31:0] exp;
	drive_op(o, a, b, im, sh, we, ra);
	next_cycle();
	exp = alu_model(o, a, b, im, sh, pc);
	if (wb_data !== exp)
		report_mismatch(o.name(), 64'(exp), 64'(wb_data));
	if (wb_we !== we)
		report_mismatch({o.name(), "_we"}, 64'(we), 64'(wb_we));
	if (wb_addr !== ra)
		report_mismatch({o.name(), "_addr"}, 64'(ra), 64'(wb_addr));
endtask

task automatic test_alu();
	oper_t       o;
	logic [31:0] r, a, b, im;
	for (int i = 0; i < 40; i++)
	begin
		r = next_rand();
		o = alu_ops[int'(r % 32'd18)];
		a = next_rand();
		b = next_rand();
		im = next_rand();
		pc = next_rand() & 32'hffff_fffc;
		r = next_rand();
		// destinations stay clear of source registers 1 and 2
		alu_case(o, a, b, im, r[4:0], r[5], 5'(32'd3 + (r % 32'd29)));
	end
	alu_case(OP_CLO, 32'hfff0_1234, 32'd0, 32'd0, 5'd0, 1'b1, 5'd3);
	alu_case(OP_CLO, 32'hffff_ffff, 32'd0, 32'd0, 5'd0, 1'b1, 5'd3);
	alu_case(OP_CLZ, 32'd0, 32'd0, 32'd0, 5'd0, 1'b1, 5'd3);
	alu_case(OP_CLZ, 32'h0001_8000, 32'd0, 32'd0, 5'd0, 1'b1, 5'd3);
endtask

task automatic test_forward();
	logic [31:0] first, second;
	first = 32'h2345_6789;
	second = first + 32'd1;
	drive_op(OP_ADDU, 32'h1234_5678, 32'h1111_1111, 32'd0, 5'd0, 1'b1, 5'd5);
	next_cycle();
	if (wb_data !== first)
		report_mismatch("fwd_first", 64'(first), 64'(wb_data));
	// stale reg1 so the result of the op above must be used
	drive_op(OP_ADDU, 32'hdead_beef, 32'd1, 32'd0, 5'd0, 1'b1, 5'd6);
	reg_addr1 = 5'd5;
	next_cycle();
	if (wb_data !== second)
		report_mismatch("fwd_reg1", 64'(second), 64'(wb_data));
	drive_op(OP_SUBU, 32'd100, 32'hffff_ffff, 32'd0, 5'd0, 1'b1, 5'd7);
	reg_addr2 = 5'd6;
	next_cycle();
	if (wb_data !== 32'd100 - second)
		report_mismatch("fwd_reg2", 64'(32'd100 - second), 64'(wb_data));
endtask

task automatic test_memory();
	oper_t       ops [6];
	logic [31:0] base, b, addr, exp_wdata;
	logic [3:0]  exp_sel;
	logic        store, mis;
	exccode_t    exp_code;
	string       tname;
	ops = '{OP_LB, OP_LH, OP_LW, OP_SB, OP_SH, OP_SW};
	for (int k = 0; k < 6; k++)
	begin
		for (int off = 0; off < 4; off++)
		begin
			base = next_rand() & 32'hffff_fffc;
			b = next_rand();
			addr = base + 32'(off);
			store = (k >= 3);
			tname = $sformatf("%s_off%0d", ops[k].name(), off);
			case (ops[k])
			OP_LB, OP_SB:
			begin
				exp_sel = 4'b0001 << off;
				exp_wdata = b << (8 * off);
				mis = 1'b0;
			end
			OP_LH, OP_SH:
			begin
				exp_sel = addr[1] ? 4'b1100 : 4'b0011;
				exp_wdata = addr[1] ? {b[15:0], 16'd0} : b;
				mis = addr[0];
			end
			default:
			begin
				exp_sel = 4'b1111;
				exp_wdata = b;
				mis = (addr[1:0] != 2'b00);
			end
			endcase
			exp_code = !mis ? EXC_NONE : (store ? EXC_ADES : EXC_ADEL);
			drive_op(ops[k], base, b, 32'(off), 5'd0, 1'b0, 5'd0);
			next_cycle();
			if ({mem_ce, mem_we} !== {1'b1, store})
				report_mismatch({tname, "_ce_we"}, 64'({1'b1, store}),
					64'({mem_ce, mem_we}));
			if (mem_addr !== addr)
				report_mismatch({tname, "_addr"}, 64'(addr), 64'(mem_addr));
			if (mem_sel !== exp_sel)
				report_mismatch({tname, "_sel"}, 64'(exp_sel), 64'(mem_sel));
			if (mem_wdata !== exp_wdata)
				report_mismatch({tname, "_wdata"}, 64'(exp_wdata), 64'(mem_wdata));
			if (except_occur !== mis || except_code !== exp_code)
				report_mismatch({tname, "_exc"}, 64'(exp_code), 64'(except_code));
			if (mis && except_extra !== addr)
				report_mismatch({tname, "_extra"}, 64'(addr), 64'(except_extra));
		end
	end
endtask

task automatic expect_exception(input string name, input oper_t o, input logic [31:0] a,
	input logic [31:0] b, input logic exp_occur, input exccode_t exp_code);
	drive_op(o, a, b, 32'd0, 5'd0, 1'b0, 5'd0);
	next_cycle();
	if (except_occur !== exp_occur)
		report_mismatch({name, "_occur"}, 64'(exp_occur), 64'(except_occur));
	if (except_code !== exp_code)
		report_mismatch({name, "_code"}, 64'(exp_code), 64'(except_code));
endtask

task automatic test_exceptions();
	expect_exception("add_ov", OP_ADD, 32'h7fff_ffff, 32'd1, 1'b1, EXC_OV);
	expect_exception("addu_wrap", OP_ADDU, 32'h7fff_ffff, 32'd1, 1'b0, EXC_NONE);
	expect_exception("add_ok", OP_ADD, 32'd5, 32'd7, 1'b0, EXC_NONE);
	expect_exception("sub_ov", OP_SUB, 32'h8000_0000, 32'd1, 1'b1, EXC_OV);
	expect_exception("subu_wrap", OP_SUBU, 32'h8000_0000, 32'd1, 1'b0, EXC_NONE);
	expect_exception("teq_hit", OP_TEQ, 32'd3, 32'd3, 1'b1, EXC_TR);
	expect_exception("teq_miss", OP_TEQ, 32'd3, 32'd4, 1'b0, EXC_NONE);
	expect_exception("tne_hit", OP_TNE, 32'd3, 32'd4, 1'b1, EXC_TR);
	expect_exception("tne_miss", OP_TNE, 32'd3, 32'd3, 1'b0, EXC_NONE);
	expect_exception("tlt_hit", OP_TLT, 32'hffff_ffff, 32'd1, 1'b1, EXC_TR);
	expect_exception("tlt_miss", OP_TLT, 32'd1, 32'hffff_ffff, 1'b0, EXC_NONE);
	expect_exception("tgeu_hit", OP_TGEU, 32'hffff_ffff, 32'd1, 1'b1, EXC_TR);
	expect_exception("tgeu_miss", OP_TGEU, 32'd1, 32'd2, 1'b0, EXC_NONE);
	expect_exception("syscall", OP_SYSCALL, 32'd0, 32'd0, 1'b1, EXC_SYS);
	expect_exception("break", OP_BREAK, 32'd0, 32'd0, 1'b1, EXC_BP);
endtask

task automatic check_multi(input string name, input oper_t o, input logic [31:0] a,
	input logic [31:0] b);
	logic [63:0] prev, exp, prod;
	int          n, exp_n;
	prev = {hi, lo};
	prod = mul_model(a, b, !(o inside {OP_MULTU, OP_MADDU, OP_MSUBU}));
	exp_n = (o inside {OP_DIV, OP_DIVU}) ? `DIV_ITERS + 1 : `MUL_CYCLES - 1;
	case (o)
	OP_MADD, OP_MADDU: exp = prev + prod;
	OP_MSUB, OP_MSUBU: exp = prev - prod;
	OP_DIV:            exp = div_model(a, b, 1'b1);
	OP_DIVU:           exp = div_model(a, b, 1'b0);
	OP_MUL:            exp = prev;
	default:           exp = prod;
	endcase
	drive_op(o, a, b, 32'd0, 5'd0, o == OP_MUL, 5'd12);
	#1;
	if (stall_req !== 1'b1)
		report_fault({name, ": stall_req did not rise"});
	n = 0;
	do
	begin
		next_cycle();
		n++;
	end
	while (stall_req && n < `DIV_ITERS + 4);
	if (stall_req)
		report_fault({name, ": stall_req never fell"});
	if (n != exp_n)
		report_mismatch({name, "_stall"}, 64'(exp_n), 64'(n));
	next_cycle();
	drive_op(OP_NOP, 32'd0, 32'd0, 32'd0, 5'd0, 1'b0, 5'd0);
	if ({hi, lo} !== exp)
		report_mismatch(name, exp, {hi, lo});
	if (o == OP_MUL && wb_data !== prod[31:0])
		report_mismatch({name, "_wb"}, 64'(prod[31:0]), 64'(wb_data));
endtask

task automatic test_hilo();
	logic [31:0] a, b;
	logic [63:0] held;
	a = next_rand();
	b = next_rand();
	drive_op(OP_MTHI, a, 32'd0, 32'd0, 5'd0, 1'b0, 5'd0);
	next_cycle();
	if (hi !== a)
		report_mismatch("mthi", 64'(a), 64'(hi));
	drive_op(OP_MTLO, b, 32'd0, 32'd0, 5'd0, 1'b0, 5'd0);
	next_cycle();
	if (lo !== b || hi !== a)
		report_mismatch("mtlo", {a, b}, {hi, lo});
	check_multi("madd", OP_MADD, next_rand(), next_rand());
	check_multi("mult", OP_MULT, next_rand(), next_rand());
	check_multi("msub", OP_MSUB, next_rand(), next_rand());
	check_multi("multu", OP_MULTU, next_rand(), next_rand());
	check_multi("mul", OP_MUL, next_rand(), next_rand());
	a = next_rand();
	b = next_rand();
	// short signed divisor so the quotient is not always zero
	b = {{16{b[31]}}, b[15:0]} | 32'd1;
	check_multi("div", OP_DIV, a, b);
	check_multi("divu", OP_DIVU, a, b);
	check_multi("div_zero", OP_DIV, 32'h8765_4321, 32'd0);
	check_multi("divu_zero", OP_DIVU, a, 32'd0);
	held = {hi, lo};
	drive_op(OP_MFHI, 32'd0, 32'd0, 32'd0, 5'd0, 1'b1, 5'd9);
	next_cycle();
	if (wb_data !== held[63:32])
		report_mismatch("mfhi", 64'(held[63:32]), 64'(wb_data));
	drive_op(OP_MFLO, 32'd0, 32'd0, 32'd0, 5'd0, 1'b1, 5'd9);
	next_cycle();
	if (wb_data !== held[31:0])
		report_mismatch("mflo", 64'(held[31:0]), 64'(wb_data));
endtask

task automatic test_flush();
	logic [63:0] prev;
	prev = {hi, lo};
	drive_op(OP_DIV, 32'd1000, 32'd7, 32'd0, 5'd0, 1'b1, 5'd13);
	repeat (3) next_cycle();
	if (stall_req !== 1'b1)
		report_fault("divide not stalling before flush");
	flush = 1'b1;
	#1;
	if (stall_req !== 1'b0)
		report_fault("stall_req still high while flush is set");
	next_cycle();
	flush = 1'b0;
	drive_op(OP_NOP, 32'd0, 32'd0, 32'd0, 5'd0, 1'b0, 5'd0);
	#1;
	if (stall_req !== 1'b0)
		report_fault("stall_req high after flush");
	if (wb_we !== 1'b0 || mem_ce !== 1'b0 || except_occur !== 1'b0)
		report_fault("flushed divide left the stage");
	if ({hi, lo} !== prev)
		report_mismatch("flush_hilo", prev, {hi, lo});
	next_cycle();
	if (wb_we !== 1'b0 || stall_req !== 1'b0 || {hi, lo} !== prev)
		report_fault("stage not idle after flush");
endtask

initial
begin
	#(WATCHDOG_NS);
	$display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
	$display("FAIL: see errors above");
	$finish;
end

initial
begin
	rng = 32'd55;
	errors = 0;
	alu_ops = '{OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
		OP_SLLV, OP_SRLV, OP_SRAV, OP_SLT, OP_SLTU, OP_LUI, OP_CLZ, OP_CLO, OP_JAL};
	rst = 1'b1;
	flush = 1'b0;
	pc = '0;
	drive_op(OP_NOP, 32'd0, 32'd0, 32'd0, 5'd0, 1'b0, 5'd0);
	repeat (2) @(posedge clk);
	#1;
	rst = 1'b0;
	check_reset();
	test_alu();
	// link op goes through the same model
	pc = 32'h0040_1000;
	alu_case(OP_JAL, 32'd0, 32'd0, 32'd0, 5'd0, 1'b1, 5'd31);
	test_forward();
	test_memory();
	test_exceptions();
	test_hilo();
	test_flush();
	$display("tests done, errors: %0d", errors);
	if (errors == 0)
		$display("PASS: all tests");
	else
		$display("FAIL: see errors above");
	$finish;
end

endmodule

// File: list.f
+incdir+include
verilog/cpu_pkg.sv
verilog/ex_count_bit.sv
verilog/ex_multi_cyc.sv
verilog/cpu_ex.sv
verilog/ex_stage.sv
sim/tb_ex_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the ex_stage testbench with Verilator, run it, and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_ex_stage -f list.f -Mdir obj_dir -o tb_ex_stage \
	&& ./obj_dir/tb_ex_stage 2>&1 | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -q "FAIL: see errors above" sim.log \
	&& { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
